// ==== rtl/memArbPkg.sv ====
package memArbPkg;

    // block and address geometry
    localparam int BLK_WIDTH     = 512;   // one cache line or signal chunk
    localparam int ADDR_WIDTH    = 32;    // byte address
    localparam int BLK_BYTES_LOG = 6;     // 64 bytes per block

    // signal table sizing
    localparam int SIG_COUNT     = 16;
    localparam int SIG_NUM_WIDTH = 4;     // log2 of SIG_COUNT
    localparam int BLK_IDX_WIDTH = 18;    // block index within signal region

    // signals live above this in memory
    localparam logic [ADDR_WIDTH-1:0] SIG_BASE_ADDR = 32'h1000_0000;

    // opcodes toward the memory controller
    typedef enum logic [1:0] {
        MEM_IDLE  = 2'b00,
        MEM_READ  = 2'b01,
        MEM_WRITE = 2'b11
    } memOp_t;

    // transfer FSM, one pair of states per kind of transfer
    typedef enum logic [3:0] {
        IDLE          = 4'b0001,
        INSTR_RD      = 4'b0010,
        INSTR_RD_DONE = 4'b0011,   // waiting on rdValid
        DATA_RD       = 4'b0100,
        DATA_RD_DONE  = 4'b0101,
        DATA_WR       = 4'b0110,
        DATA_WR_DONE  = 4'b0111,   // eviction ack cycle
        ACCEL_RD      = 4'b1000,
        ACCEL_RD_DONE = 4'b1001,
        ACCEL_WR      = 4'b1010,
        ACCEL_WR_DONE = 4'b1011
    } arbState_t;

endpackage

// ==== rtl/accelAddrIf.sv ====
`timescale 1ns/100ps

interface accelAddrIf;
    import memArbPkg::*;

    logic                  start;     // signal granted, load start block
    logic                  blkDone;   // one block moved, advance index
    logic [ADDR_WIDTH-1:0] blkAddr;   // byte address of current block
    logic                  lastBlk;   // current block is the end block

    modport arb (
        output start,
        output blkDone,
        input  blkAddr,
        input  lastBlk
    );

    modport gen (
        input  start,
        input  blkDone,
        output blkAddr,
        output lastBlk
    );

endinterface

// ==== rtl/sigTable.sv ====
`timescale 1ns/100ps

module sigTable (
    input  logic                               clk,
    input  logic                               rst,
    // host config port
    input  logic                               wrEn,
    input  logic [memArbPkg::SIG_NUM_WIDTH-1:0] wrSigNum,
    input  logic [memArbPkg::BLK_IDX_WIDTH-1:0] wrStartBlk,
    input  logic [memArbPkg::BLK_IDX_WIDTH-1:0] wrEndBlk,
    // lookup for the address generator
    input  logic [memArbPkg::SIG_NUM_WIDTH-1:0] rdSigNum,
    output logic [memArbPkg::BLK_IDX_WIDTH-1:0] startBlk,
    output logic [memArbPkg::BLK_IDX_WIDTH-1:0] endBlk
);
    import memArbPkg::*;

    // start / end block index per signal number
    logic [BLK_IDX_WIDTH-1:0] startTbl [SIG_COUNT];
    logic [BLK_IDX_WIDTH-1:0] endTbl   [SIG_COUNT];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SIG_COUNT; i++) begin
                startTbl[i] <= '0;
                endTbl[i]   <= '0;
            end
        end else if (wrEn) begin
            startTbl[wrSigNum] <= wrStartBlk;   // visible next clock
            endTbl[wrSigNum]   <= wrEndBlk;
        end
    end

    // async read, sigNum is held for the whole signal
    assign startBlk = startTbl[rdSigNum];
    assign endBlk   = endTbl[rdSigNum];

endmodule

// ==== rtl/accelAddrGen.sv ====
`timescale 1ns/100ps

module accelAddrGen (
    input  logic                               clk,
    input  logic                               rst,
    accelAddrIf.gen                            addrBus,
    input  logic [memArbPkg::BLK_IDX_WIDTH-1:0] startBlk,
    input  logic [memArbPkg::BLK_IDX_WIDTH-1:0] endBlk
);
    import memArbPkg::*;

    logic [BLK_IDX_WIDTH-1:0] blkIdx;   // block currently being moved
    logic [ADDR_WIDTH-1:0]    blkOffset;

    // index walks from start block toward end block
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            blkIdx <= '0;
        end else if (addrBus.start) begin
            blkIdx <= startBlk;              // grant cycle, first block
        end else if (addrBus.blkDone) begin
            blkIdx <= blkIdx + 1'b1;         // next block ready for the following cycle
        end
    end

    // index to byte offset inside the signal region
    assign blkOffset = ADDR_WIDTH'(blkIdx) << BLK_BYTES_LOG;

    assign addrBus.blkAddr = SIG_BASE_ADDR + blkOffset;

    // end block is inclusive
    assign addrBus.lastBlk = (blkIdx == endBlk);

endmodule

// ==== rtl/memArb.sv ====
`timescale 1ns/100ps

module memArb (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            halt,            // blocks new grants only
    // instruction cache
    input  logic                            instrReq,
    input  logic [memArbPkg::ADDR_WIDTH-1:0] instrAddr,
    output logic [memArbPkg::BLK_WIDTH-1:0]  instrBlk,
    output logic                            instrBlkValid,
    // data cache
    input  logic                            dataReq,
    input  logic                            dataEvictReq,
    input  logic [memArbPkg::ADDR_WIDTH-1:0] dataAddr,
    input  logic [memArbPkg::BLK_WIDTH-1:0]  dataBlk2Mem,
    output logic [memArbPkg::BLK_WIDTH-1:0]  dataBlk,
    output logic                            dataBlkValid,
    output logic                            dataEvictAck,
    // accelerator buffer
    input  logic                            accelRd,
    input  logic                            accelWr,
    input  logic [memArbPkg::BLK_WIDTH-1:0]  accelBlk2Mem,
    output logic [memArbPkg::BLK_WIDTH-1:0]  accelBlk2Buf,
    output logic                            accelRdBlkDone,
    output logic                            accelWrBlkDone,
    output logic                            sigDone,
    // memory controller
    input  logic                            txDone,
    input  logic                            rdValid,
    input  logic [memArbPkg::BLK_WIDTH-1:0]  memDataIn,
    output memArbPkg::memOp_t               memOp,
    output logic [memArbPkg::ADDR_WIDTH-1:0] ioAddr,
    output logic [memArbPkg::BLK_WIDTH-1:0]  memDataOut,
    // address generator
    accelAddrIf.arb                         addrBus
);
    import memArbPkg::*;

    arbState_t             state, nextState;
    logic [ADDR_WIDTH-1:0] instrAddrAligned;
    logic [ADDR_WIDTH-1:0] dataAddrAligned;
    logic                  clientResp;   // any end-of-transfer pulse this cycle
    logic                  holdOff;      // requester still dropping its request
    logic                  grantOk;

    // controller wants block-aligned addresses
    assign instrAddrAligned = {instrAddr[ADDR_WIDTH-1:BLK_BYTES_LOG], {BLK_BYTES_LOG{1'b0}}};
    assign dataAddrAligned  = {dataAddr[ADDR_WIDTH-1:BLK_BYTES_LOG], {BLK_BYTES_LOG{1'b0}}};

    assign clientResp = instrBlkValid | dataBlkValid | dataEvictAck | sigDone;
    assign grantOk    = !halt && !holdOff;

    always_comb begin
        nextState      = state;
        memOp          = MEM_IDLE;
        ioAddr         = '0;
        memDataOut     = '0;
        instrBlk       = '0;
        instrBlkValid  = 1'b0;
        dataBlk        = '0;
        dataBlkValid   = 1'b0;
        dataEvictAck   = 1'b0;
        accelBlk2Buf   = '0;
        accelRdBlkDone = 1'b0;
        accelWrBlkDone = 1'b0;
        sigDone        = 1'b0;
        addrBus.start   = 1'b0;
        addrBus.blkDone = 1'b0;

        case (state)
            IDLE: begin
                // fixed priority, accel > data evict > data fill > instr
                if (grantOk) begin
                    if (accelRd || accelWr) begin
                        addrBus.start = 1'b1;           // latch start block
                        nextState = accelRd ? ACCEL_RD : ACCEL_WR;
                    end else if (dataEvictReq) begin
                        nextState = DATA_WR;
                    end else if (dataReq) begin
                        nextState = DATA_RD;
                    end else if (instrReq) begin
                        nextState = INSTR_RD;
                    end
                end
            end
            INSTR_RD, INSTR_RD_DONE: begin
                if (state == INSTR_RD) begin
                    memOp  = MEM_READ;
                    ioAddr = instrAddrAligned;
                end
                instrBlk = memDataIn;
                // rdValid may land with txDone or any time after
                if ((state == INSTR_RD_DONE || txDone) && rdValid) begin
                    instrBlkValid = 1'b1;
                    nextState     = IDLE;
                end else if (txDone) begin
                    nextState = INSTR_RD_DONE;
                end
            end
            DATA_RD, DATA_RD_DONE: begin
                if (state == DATA_RD) begin
                    memOp  = MEM_READ;
                    ioAddr = dataAddrAligned;
                end
                dataBlk = memDataIn;
                if ((state == DATA_RD_DONE || txDone) && rdValid) begin
                    dataBlkValid = 1'b1;
                    nextState    = IDLE;
                end else if (txDone) begin
                    nextState = DATA_RD_DONE;
                end
            end
            DATA_WR: begin
                memOp      = MEM_WRITE;
                ioAddr     = dataAddrAligned;
                memDataOut = dataBlk2Mem;          // victim line
                if (txDone) begin
                    nextState = DATA_WR_DONE;
                end
            end
            DATA_WR_DONE: begin
                dataEvictAck = 1'b1;
                nextState    = IDLE;
            end
            ACCEL_RD, ACCEL_RD_DONE: begin
                if (state == ACCEL_RD) begin
                    memOp  = MEM_READ;
                    ioAddr = addrBus.blkAddr;
                end
                accelBlk2Buf = memDataIn;
                if ((state == ACCEL_RD_DONE || txDone) && rdValid) begin
                    accelRdBlkDone  = 1'b1;
                    addrBus.blkDone = 1'b1;
                    sigDone         = addrBus.lastBlk;
                    nextState       = addrBus.lastBlk ? IDLE : ACCEL_RD;   // stay on the signal
                end else if (txDone) begin
                    nextState = ACCEL_RD_DONE;
                end
            end
            ACCEL_WR: begin
                memOp      = MEM_WRITE;
                ioAddr     = addrBus.blkAddr;
                memDataOut = accelBlk2Mem;         // buffer holds the block
                if (txDone) begin
                    nextState = ACCEL_WR_DONE;
                end
            end
            ACCEL_WR_DONE: begin
                accelWrBlkDone  = 1'b1;            // buffer presents next block after this
                addrBus.blkDone = 1'b1;
                sigDone         = addrBus.lastBlk;
                nextState       = addrBus.lastBlk ? IDLE : ACCEL_WR;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            holdOff <= 1'b0;
        end else begin
            state   <= nextState;
            // client drops its request one cycle after the response
            holdOff <= clientResp;
        end
    end

endmodule

// ==== rtl/memArbTop.sv ====
`timescale 1ns/100ps

module memArbTop (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               halt,
    // signal table config
    input  logic                               cfgWrEn,
    input  logic [memArbPkg::SIG_NUM_WIDTH-1:0] cfgSigNum,
    input  logic [memArbPkg::BLK_IDX_WIDTH-1:0] cfgStartBlk,
    input  logic [memArbPkg::BLK_IDX_WIDTH-1:0] cfgEndBlk,
    // instruction cache
    input  logic                               instrReq,
    input  logic [memArbPkg::ADDR_WIDTH-1:0]    instrAddr,
    output logic [memArbPkg::BLK_WIDTH-1:0]     instrBlk,
    output logic                               instrBlkValid,
    // data cache
    input  logic                               dataReq,
    input  logic                               dataEvictReq,
    input  logic [memArbPkg::ADDR_WIDTH-1:0]    dataAddr,
    input  logic [memArbPkg::BLK_WIDTH-1:0]     dataBlk2Mem,
    output logic [memArbPkg::BLK_WIDTH-1:0]     dataBlk,
    output logic                               dataBlkValid,
    output logic                               dataEvictAck,
    // accelerator buffer
    input  logic                               accelRd,
    input  logic                               accelWr,
    input  logic [memArbPkg::SIG_NUM_WIDTH-1:0] sigNum,
    input  logic [memArbPkg::BLK_WIDTH-1:0]     accelBlk2Mem,
    output logic [memArbPkg::BLK_WIDTH-1:0]     accelBlk2Buf,
    output logic                               accelRdBlkDone,
    output logic                               accelWrBlkDone,
    output logic                               sigDone,
    // memory controller
    input  logic                               txDone,
    input  logic                               rdValid,
    input  logic [memArbPkg::BLK_WIDTH-1:0]     memDataIn,
    output memArbPkg::memOp_t                  memOp,
    output logic [memArbPkg::ADDR_WIDTH-1:0]    ioAddr,
    output logic [memArbPkg::BLK_WIDTH-1:0]     memDataOut
);
    import memArbPkg::*;

    logic [BLK_IDX_WIDTH-1:0] startBlk;   // table lookup for held sigNum
    logic [BLK_IDX_WIDTH-1:0] endBlk;

    accelAddrIf addrBus ();

    sigTable i_sigTable (
        .clk        (clk),
        .rst        (rst),
        .wrEn       (cfgWrEn),
        .wrSigNum   (cfgSigNum),
        .wrStartBlk (cfgStartBlk),
        .wrEndBlk   (cfgEndBlk),
        .rdSigNum   (sigNum),
        .startBlk   (startBlk),
        .endBlk     (endBlk)
    );

    accelAddrGen i_accelAddrGen (
        .clk      (clk),
        .rst      (rst),
        .addrBus  (addrBus.gen),
        .startBlk (startBlk),
        .endBlk   (endBlk)
    );

    memArb i_memArb (
        .clk            (clk),
        .rst            (rst),
        .halt           (halt),
        .instrReq       (instrReq),
        .instrAddr      (instrAddr),
        .instrBlk       (instrBlk),
        .instrBlkValid  (instrBlkValid),
        .dataReq        (dataReq),
        .dataEvictReq   (dataEvictReq),
        .dataAddr       (dataAddr),
        .dataBlk2Mem    (dataBlk2Mem),
        .dataBlk        (dataBlk),
        .dataBlkValid   (dataBlkValid),
        .dataEvictAck   (dataEvictAck),
        .accelRd        (accelRd),
        .accelWr        (accelWr),
        .accelBlk2Mem   (accelBlk2Mem),
        .accelBlk2Buf   (accelBlk2Buf),
        .accelRdBlkDone (accelRdBlkDone),
        .accelWrBlkDone (accelWrBlkDone),
        .sigDone        (sigDone),
        .txDone         (txDone),
        .rdValid        (rdValid),
        .memDataIn      (memDataIn),
        .memOp          (memOp),
        .ioAddr         (ioAddr),
        .memDataOut     (memDataOut),
        .addrBus        (addrBus.arb)
    );

endmodule

// ==== test/memArb_chk.sv ====
`timescale 1ns/100ps

module memArb_chk (
    input logic                            clk,
    input logic                            rst,
    input memArbPkg::memOp_t               memOp,
    input logic [memArbPkg::ADDR_WIDTH-1:0] ioAddr,
    input logic                            txDone,
    input logic                            instrBlkValid,
    input logic                            dataBlkValid,
    input logic                            dataEvictAck,
    input logic                            accelRdBlkDone,
    input logic                            accelWrBlkDone
);
    import memArbPkg::*;

    logic anyResp;
    logic sawOp;   // controller op seen since the last response

    assign anyResp = instrBlkValid | dataBlkValid | dataEvictAck | accelRdBlkDone |
                     accelWrBlkDone;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) sawOp <= 1'b0;
        else if (anyResp) sawOp <= 1'b0;
        else if (memOp != MEM_IDLE) sawOp <= 1'b1;
    end

    // request held until the controller takes it
    assert property (@(posedge clk) disable iff (rst)
        (memOp != MEM_IDLE && !txDone) |=> (memOp == $past(memOp) && ioAddr == $past(ioAddr)))
        else $error("memOp or ioAddr changed before txDone");

    assert property (@(posedge clk) disable iff (rst) instrBlkValid |=> !instrBlkValid)
        else $error("instrBlkValid longer than one cycle");
    assert property (@(posedge clk) disable iff (rst) dataBlkValid |=> !dataBlkValid)
        else $error("dataBlkValid longer than one cycle");
    assert property (@(posedge clk) disable iff (rst) dataEvictAck |=> !dataEvictAck)
        else $error("dataEvictAck longer than one cycle");

    assert property (@(posedge clk) disable iff (rst) anyResp |-> (sawOp || memOp != MEM_IDLE))
        else $error("response without a controller transfer");

endmodule

bind memArbTop memArb_chk chkInst (.*);

// ==== test/memArbTb.sv ====
`timescale 1ns/100ps

module memArbTb;
    import memArbPkg::*;

    localparam int NUM_ROWS = 9;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 64 + 40;   // rows plus reset and config
    // client kinds in the stimulus table
    localparam int K_INSTR = 0, K_EVICT = 1, K_RDEVICT = 2, K_ACCRD = 3, K_ACCWR = 4;
    localparam int K_ALLRD = 5, K_ALLWR = 6, K_DATA = 7;

    logic clk, rst, halt, cfgWrEn;
    logic [SIG_NUM_WIDTH-1:0] cfgSigNum, sigNum;
    logic [BLK_IDX_WIDTH-1:0] cfgStartBlk, cfgEndBlk;
    logic instrReq, dataReq, dataEvictReq, accelRd, accelWr, txDone, rdValid;
    logic [ADDR_WIDTH-1:0] instrAddr, dataAddr, ioAddr;
    logic [BLK_WIDTH-1:0] dataBlk2Mem, accelBlk2Mem, memDataIn, memDataOut;
    logic [BLK_WIDTH-1:0] instrBlk, dataBlk, accelBlk2Buf;
    logic instrBlkValid, dataBlkValid, dataEvictAck, accelRdBlkDone, accelWrBlkDone, sigDone;
    memOp_t memOp;

    // kind, cache address, sigNum, write seed, halt
    int rowKind [NUM_ROWS] = '{K_INSTR, K_EVICT, K_RDEVICT, K_ACCRD, K_ACCWR,
                                K_ALLRD, K_ALLWR, K_INSTR, K_DATA};
    logic [31:0] rowAddr [NUM_ROWS] = '{32'h0000_1234, 32'h0000_2f80, 32'h0000_3044, 0, 0,
                                        32'h0000_4010, 32'h0000_6030, 32'h0000_8fff,
                                        32'h0000_9001};
    int rowSig [NUM_ROWS] = '{0, 0, 0, 3, 12, 7, 3, 0, 0};
    logic [31:0] rowSeed [NUM_ROWS] = '{0, 32'ha5a5_0000, 32'h5a5a_1000, 0, 32'hc0de_0000,
                                        0, 32'h7777_0000, 0, 0};
    logic rowHalt [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 1};
    // signal table contents loaded over the config port
    int cfgStart [SIG_COUNT];
    int cfgEnd   [SIG_COUNT];

    logic [31:0] lfsr = 32'h0cf9_5241;
    logic [31:0] logAddr [$];    // controller transfer log
    logic        logWr   [$];
    logic [BLK_WIDTH-1:0] logData [$];
    int errCount = 0;
    int cycleCount = 0;
    bit busy = 0;
    int waitCnt = 0;

    memArbTop i_memArbTop (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32,22,2,1
    endfunction

    // distinct words per block so swapped blocks show up
    function automatic logic [BLK_WIDTH-1:0] blockFromSeed(input logic [31:0] seed, input int idx);
        logic [BLK_WIDTH-1:0] blk;
        for (int k = 0; k < BLK_WIDTH / 32; k++) begin
            blk[k*32 +: 32] = seed + idx * 32'h100 + k;
        end
        return blk;
    endfunction

    function automatic logic [31:0] alignAddr(input logic [31:0] a);
        return a & ~((32'd1 << BLK_BYTES_LOG) - 1);
    endfunction

    task automatic compare(input string name, input logic [BLK_WIDTH-1:0] got,
                           input logic [BLK_WIDTH-1:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // controller model, 0..3 cycle delay then txDone, read data with it
    always @(posedge clk) begin
        txDone  <= 1'b0;
        rdValid <= 1'b0;
        if (!rst && memOp != MEM_IDLE && !txDone) begin
            if (!busy) begin
                busy = 1;
                lfsr = lfsrStep(lfsr);
                waitCnt = lfsr[0];
                lfsr = lfsrStep(lfsr);
                waitCnt = waitCnt * 2 + lfsr[0];
            end
            if (waitCnt == 0) begin
                busy = 0;
                txDone <= 1'b1;
                logAddr.push_back(ioAddr);
                logWr.push_back(memOp == MEM_WRITE);
                logData.push_back(memOp == MEM_WRITE ? memDataOut : '0);
                if (memOp == MEM_READ) begin
                    rdValid   <= 1'b1;
                    memDataIn <= {(BLK_WIDTH / 32){ioAddr}};   // address replicated
                end
            end else begin
                waitCnt--;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles waiting for a response", cycleCount);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic runRow(input int r);
        int kind, sg, blkCnt, nBlk;
        bit useAccel, isWr, useEvict, useData, useInstr;
        bit pInstr, pData, pEvict, pAccel;
        logic [31:0] cAddr, seed;
        logic [31:0] expAddr [$];
        logic        expWr [$];
        logic [BLK_WIDTH-1:0] expData [$];
        kind = rowKind[r];
        sg = rowSig[r];
        cAddr = rowAddr[r];
        seed = rowSeed[r];
        useAccel = kind inside {K_ACCRD, K_ACCWR, K_ALLRD, K_ALLWR};
        isWr     = kind inside {K_ACCWR, K_ALLWR};
        useEvict = kind inside {K_EVICT, K_RDEVICT};
        useData  = kind inside {K_RDEVICT, K_ALLRD, K_ALLWR, K_DATA};
        useInstr = kind inside {K_INSTR, K_ALLRD, K_ALLWR};
        nBlk = cfgEnd[sg] - cfgStart[sg] + 1;
        logAddr.delete();
        logWr.delete();
        logData.delete();
        // expected controller order follows the fixed priority
        if (useAccel) begin
            for (int b = 0; b < nBlk; b++) begin
                expAddr.push_back(SIG_BASE_ADDR + ((cfgStart[sg] + b) << BLK_BYTES_LOG));
                expWr.push_back(isWr);
                expData.push_back(isWr ? blockFromSeed(seed, b) : '0);
            end
        end
        if (useEvict) begin
            expAddr.push_back(alignAddr(cAddr));
            expWr.push_back(1'b1);
            expData.push_back(blockFromSeed(seed, 0));
        end
        if (useData) begin
            expAddr.push_back(alignAddr(useInstr ? cAddr + 32'h1000 : cAddr));
            expWr.push_back(1'b0);
            expData.push_back('0);
        end
        if (useInstr) begin
            expAddr.push_back(alignAddr(cAddr));
            expWr.push_back(1'b0);
            expData.push_back('0);
        end
        @(posedge clk);
        halt <= rowHalt[r];
        instrReq <= useInstr;
        instrAddr <= cAddr;
        dataReq <= useData;
        dataEvictReq <= useEvict;
        dataAddr <= useInstr ? cAddr + 32'h1000 : cAddr;
        dataBlk2Mem <= blockFromSeed(seed, 0);
        accelRd <= useAccel && !isWr;
        accelWr <= useAccel && isWr;
        sigNum <= sg[SIG_NUM_WIDTH-1:0];
        accelBlk2Mem <= blockFromSeed(seed, 0);
        if (rowHalt[r]) begin
            repeat (8) begin
                @(negedge clk);
                compare("memOp during halt", memOp, MEM_IDLE);
            end
            @(posedge clk);
            halt <= 1'b0;
        end
        pInstr = useInstr;
        pData = useData;
        pEvict = useEvict;
        pAccel = useAccel;
        blkCnt = 0;
        while (pInstr || pData || pEvict || pAccel) begin
            @(negedge clk);
            if (instrBlkValid) begin
                compare("instrBlk", instrBlk, {(BLK_WIDTH / 32){alignAddr(cAddr)}});
                pInstr = 0;
            end
            if (dataBlkValid) begin
                compare("dataBlk", dataBlk, {(BLK_WIDTH / 32){expAddr[expAddr.size() - 1 -
                        (useInstr ? 1 : 0)]}});
                pData = 0;
            end
            if (dataEvictAck) begin
                // eviction write already taken by the controller
                compare("transfers at dataEvictAck", logAddr.size(), (useAccel ? nBlk : 0) + 1);
                pEvict = 0;
            end
            if (accelRdBlkDone || accelWrBlkDone) begin
                if (accelRdBlkDone) begin
                    compare("accelBlk2Buf", accelBlk2Buf, {(BLK_WIDTH / 32){expAddr[blkCnt]}});
                end
                compare("transfers at block done", logAddr.size(), blkCnt + 1);
                compare("sigDone", sigDone, blkCnt == nBlk - 1);
                blkCnt++;
                if (sigDone) pAccel = 0;
            end
            @(posedge clk);
            // requesters drop one cycle after their response
            if (!pInstr) instrReq <= 1'b0;
            if (!pData) dataReq <= 1'b0;
            if (!pEvict) dataEvictReq <= 1'b0;
            if (!pAccel) begin
                accelRd <= 1'b0;
                accelWr <= 1'b0;
            end
            accelBlk2Mem <= blockFromSeed(seed, blkCnt);   // next write block
        end
        compare("transfer count", logAddr.size(), expAddr.size());
        foreach (expAddr[i]) begin
            compare("ioAddr", logAddr[i], expAddr[i]);
            compare("memOp write", logWr[i], expWr[i]);
            if (expWr[i]) compare("memDataOut", logData[i], expData[i]);
        end
    endtask

    initial begin
        rst = 1'b1;
        halt = 1'b0;
        cfgWrEn = 1'b0;
        cfgSigNum = '0;
        cfgStartBlk = '0;
        cfgEndBlk = '0;
        instrReq = 1'b0;
        instrAddr = '0;
        dataReq = 1'b0;
        dataEvictReq = 1'b0;
        dataAddr = '0;
        dataBlk2Mem = '0;
        accelRd = 1'b0;
        accelWr = 1'b0;
        sigNum = '0;
        accelBlk2Mem = '0;
        txDone = 1'b0;
        rdValid = 1'b0;
        memDataIn = '0;
        foreach (cfgStart[i]) begin
            cfgStart[i] = 0;
            cfgEnd[i] = 0;
        end
        cfgStart[3] = 2;     // four blocks
        cfgEnd[3] = 5;
        cfgStart[7] = 10;    // single block
        cfgEnd[7] = 10;
        cfgStart[12] = 100;
        cfgEnd[12] = 102;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (cfgStart[i]) begin
            @(posedge clk);
            cfgWrEn <= 1'b1;
            cfgSigNum <= SIG_NUM_WIDTH'(i);
            cfgStartBlk <= BLK_IDX_WIDTH'(cfgStart[i]);
            cfgEndBlk <= BLK_IDX_WIDTH'(cfgEnd[i]);
        end
        @(posedge clk);
        cfgWrEn <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
            repeat (2) @(posedge clk);   // let holdOff clear
        end
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/memArbPkg.sv
rtl/accelAddrIf.sv
rtl/sigTable.sv
rtl/accelAddrGen.sv
rtl/memArb.sv
rtl/memArbTop.sv
test/memArb_chk.sv
test/memArbTb.sv

// ==== Bender.yml ====
package:
  name: memArb

sources:
  - rtl/memArbPkg.sv
  - rtl/accelAddrIf.sv
  - rtl/sigTable.sv
  - rtl/accelAddrGen.sv
  - rtl/memArb.sv
  - rtl/memArbTop.sv
  - target: test
    files:
      - test/memArb_chk.sv
      - test/memArbTb.sv
